/* knight_pkg.sv */
//////////////////////////////
// Knight command processor shared types.
// Widths, command and IR structs, opcode and FSM enums.
// Speed ramp, nudge and alignment constants.
//////////////////////////////
package knight_pkg;

  typedef logic [15:0]        cmd_t;        // Raw command word.
  typedef logic signed [11:0] heading_t;    // Gyro heading and PID error.
  typedef logic [9:0]         frwrd_t;      // Forward speed.
  typedef logic [3:0]         sq_cnt_t;     // Squares to travel.
  typedef logic [4:0]         pulse_cnt_t;  // Centre line edges, two per square.

  typedef struct packed {
    logic [3:0] op;                         // Opcode field.
    logic [7:0] hdg_code;                   // Heading code field.
    sq_cnt_t    squares;                    // Square count field.
  } cmd_fields_t;

  typedef struct packed {
    logic lft;                              // Left IR, drifted right.
    logic cntr;                             // Centre IR, on a line.
    logic rght;                             // Right IR, drifted left.
  } ir_t;

  typedef enum logic [3:0] {
    CAL     = 4'h2,                         // Gyro calibration.
    MOV     = 4'h4,                         // Plain move.
    FANFARE = 4'h5,                         // Move with fanfare.
    TOUR    = 4'h6                          // Start the knight's tour.
  } op_t;

  typedef enum logic [2:0] {
    IDLE,                                   // Waiting on cmd_rdy.
    CALIBRATE,                              // Waiting on cal_done.
    ALIGN,                                  // Turning to the new heading.
    INCR,                                   // Ramping speed up.
    DECR                                    // Ramping speed down.
  } fsm_state_t;

  //////////////////////////////
  // Ramp steps and nudges
  localparam frwrd_t   INC_FAST   = 10'h020;
  localparam frwrd_t   INC_SLOW   = 10'h003;
  localparam frwrd_t   DEC_FAST   = 10'h040;
  localparam frwrd_t   DEC_SLOW   = 10'h006;
  localparam heading_t NUDGE_FAST = 12'h1FF;
  localparam heading_t NUDGE_SLOW = 12'h05F;

  localparam logic [11:0] ALIGN_THRESH = 12'h02C;  // Close enough to start moving.

endpackage

/* frwrd_ramp.sv */
//////////////////////////////
// Forward speed register.
// Ramps on heading_rdy, saturates at max speed and at zero.
//////////////////////////////
`timescale 1ns/1ns

module frwrd_ramp import knight_pkg::*; #(
  parameter bit fast_sim = 1'b1            // Selects the large ramp steps.
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   heading_rdy,               // Step enable.
  input  logic   frwrd_clr,                 // Clear speed.
  input  logic   frwrd_inc,                 // Ramp up.
  input  logic   frwrd_dec,                 // Ramp down.
  output frwrd_t frwrd,                     // Speed to the motor mixer.
  output logic   frwrd_zero                 // Speed is zero.
);

  localparam frwrd_t INC_STEP = fast_sim ? INC_FAST : INC_SLOW;
  localparam frwrd_t DEC_STEP = fast_sim ? DEC_FAST : DEC_SLOW;

  logic max_spd;                            // Two top bits set.

  assign max_spd    = &frwrd[9:8];
  assign frwrd_zero = (frwrd == '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (frwrd_clr) begin
      frwrd <= '0;
    end else if (heading_rdy) begin         // One step per gyro sample.
      if (frwrd_inc) begin
        if (!max_spd) begin
          frwrd <= frwrd + INC_STEP;
        end
      end else if (frwrd_dec) begin
        if (frwrd < DEC_STEP) begin
          frwrd <= '0;                      // Clamp, no wrap.
        end else begin
          frwrd <= frwrd - DEC_STEP;
        end
      end
    end
  end

endmodule

/* square_counter.sv */
//////////////////////////////
// Square counter.
// Centre IR edge detect, edge count, move-done compare.
//////////////////////////////
`timescale 1ns/1ns

module square_counter import knight_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cmd_load,                 // Move accepted.
  input  sq_cnt_t squares,                  // Squares in the command.
  input  logic    cntr_ir,                  // Centre IR level.
  output logic    move_done                 // Target edge count reached.
);

  logic       cntr_prev;                    // Last centre IR level.
  logic       cntr_rise;                    // Rising edge seen.
  sq_cnt_t    sq_target;                    // Squares of this move.
  pulse_cnt_t pulse_cnt;                    // Edges since the move began.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
    end else begin
      cntr_prev <= cntr_ir;
    end
  end

  assign cntr_rise = cntr_ir & ~cntr_prev;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sq_target <= '0;
    end else if (cmd_load) begin
      sq_target <= squares;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pulse_cnt <= '0;
    end else if (cmd_load) begin
      pulse_cnt <= '0;                      // Fresh count per move.
    end else if (cntr_rise) begin
      pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  // Two line crossings per square.
  assign move_done = (pulse_cnt == {sq_target, 1'b0});

endmodule

/* heading_err.sv */
//////////////////////////////
// Heading error for the PID.
// Desired heading register, IR nudge, error, alignment flag.
//////////////////////////////
`timescale 1ns/1ns

module heading_err import knight_pkg::*; #(
  parameter bit fast_sim = 1'b1            // Selects the large nudge.
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_load,              // Move accepted.
  input  logic [7:0] hdg_code,              // Heading code of the command.
  input  heading_t   heading,               // Gyro heading.
  input  ir_t        ir,                    // Line sensors.
  output heading_t   error,                 // Heading minus desired plus nudge.
  output logic       aligned                // Error magnitude below threshold.
);

  localparam heading_t NUDGE = fast_sim ? NUDGE_FAST : NUDGE_SLOW;

  heading_t    desired_hdg;                 // Heading of the current move.
  heading_t    nudge;                       // Correction for drift off the line.
  logic [11:0] err_abs;                     // Magnitude of the error.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      desired_hdg <= '0;
    end else if (cmd_load) begin
      if (hdg_code == 8'h00) begin
        desired_hdg <= '0;                  // North stays exactly zero.
      end else begin
        desired_hdg <= {hdg_code, 4'hF};
      end
    end
  end

  // Left wins when both sensors see the line.
  always_comb begin
    if (ir.lft) begin
      nudge = NUDGE;
    end else if (ir.rght) begin
      nudge = ~NUDGE;                       // One's complement, -0x200 when fast.
    end else begin
      nudge = '0;
    end
  end

  assign error = heading - desired_hdg + nudge;

  assign err_abs = error[11] ? 12'(-error) : 12'(error);
  assign aligned = (err_abs < ALIGN_THRESH);

endmodule

/* cmd_fsm.sv */
//////////////////////////////
// Command FSM.
// Accepts commands in IDLE, latches the move opcode,
// runs calibration and move sequences.
//////////////////////////////
`timescale 1ns/1ns

module cmd_fsm import knight_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  op_t  op,                          // Opcode of the waiting command.
  input  logic cmd_rdy,                     // Command valid level.
  input  logic cal_done,                    // Gyro calibration finished.
  input  logic aligned,                     // Heading error small.
  input  logic move_done,                   // All squares crossed.
  input  logic frwrd_zero,                  // Speed back at zero.
  output logic clr_cmd_rdy,                 // Command consumed.
  output logic strt_cal,                    // Start gyro calibration.
  output logic send_resp,                   // Command finished.
  output logic tour_go,                     // Start the tour.
  output logic fanfare_go,                  // Play the fanfare.
  output logic moving,                      // Robot in motion.
  output logic cmd_load,                    // Move accepted, load targets.
  output logic frwrd_clr,                   // Clear speed.
  output logic frwrd_inc,                   // Ramp speed up.
  output logic frwrd_dec                    // Ramp speed down.
);

  fsm_state_t state;                        // Current state.
  fsm_state_t nxt_state;                    // Next state.
  op_t        op_q;                         // Opcode of the move in progress.

  //////////////////////////////
  // State and opcode registers
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      op_q <= MOV;
    end else if (cmd_load) begin
      op_q <= op;                           // Later cmd changes leave the move alone.
    end
  end

  //////////////////////////////
  // Transitions and strobes
  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    cmd_load    = 1'b0;
    frwrd_clr   = 1'b0;
    frwrd_inc   = 1'b0;
    frwrd_dec   = 1'b0;

    case (state)
      IDLE: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;               // Every command seen here is taken.
          case (op)
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            TOUR: begin
              tour_go = 1'b1;               // Single pulse, stay in IDLE.
            end
            default: begin                  // MOV, FANFARE and unknown codes.
              cmd_load  = 1'b1;
              nxt_state = ALIGN;
            end
          endcase
        end
      end

      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;                 // First cycle of cal_done only.
          nxt_state = IDLE;
        end
      end

      ALIGN: begin
        if (aligned) begin
          moving    = 1'b1;
          frwrd_clr = 1'b1;                 // Start the ramp from rest.
          nxt_state = INCR;
        end
      end

      INCR: begin
        moving    = 1'b1;
        frwrd_inc = 1'b1;
        if (move_done) begin
          fanfare_go = (op_q == FANFARE);
          nxt_state  = DECR;
        end
      end

      DECR: begin
        frwrd_dec = 1'b1;
        if (frwrd_zero) begin
          send_resp = 1'b1;                 // Stopped, report the move.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;
        end
      end

      default: begin
        nxt_state = IDLE;                   // Unused encodings recover.
      end
    endcase
  end

endmodule

/* cmd_proc.sv */
//////////////////////////////
// Knight command processor top level.
// Splits the command word and IR bits, wires the FSM,
// the speed ramp, the square counter and the heading error.
//////////////////////////////
`timescale 1ns/1ns

module cmd_proc import knight_pkg::*; #(
  parameter bit fast_sim = 1'b1            // Large ramp steps for short simulations.
) (
  input  logic     clk,
  input  logic     rst_n,
  input  cmd_t     cmd,                     // Command from the BLE link.
  input  logic     cmd_rdy,                 // Command valid level.
  input  logic     cal_done,                // Gyro calibration finished.
  input  heading_t heading,                 // Gyro heading.
  input  logic     heading_rdy,             // One cycle per new heading.
  input  ir_t      ir,                      // Line sensors.
  output logic     clr_cmd_rdy,             // Command consumed.
  output logic     send_resp,               // Command finished.
  output logic     strt_cal,                // Start gyro calibration.
  output logic     moving,                  // Robot in motion.
  output heading_t error,                   // Error to the PID.
  output frwrd_t   frwrd,                   // Forward speed.
  output logic     tour_go,                 // Start the tour.
  output logic     fanfare_go               // Play the fanfare.
);

  cmd_fields_t cmd_f;                       // Command viewed as fields.
  op_t         op;                          // Decoded opcode.
  logic        cmd_load;                    // Move accepted.
  logic        frwrd_clr;
  logic        frwrd_inc;
  logic        frwrd_dec;
  logic        frwrd_zero;
  logic        move_done;
  logic        aligned;

  assign cmd_f = cmd;
  assign op    = op_t'(cmd_f.op);           // Unlisted codes fall to the move path.

  cmd_fsm u_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .op          (op),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .aligned     (aligned),
    .move_done   (move_done),
    .frwrd_zero  (frwrd_zero),
    .clr_cmd_rdy (clr_cmd_rdy),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .cmd_load    (cmd_load),
    .frwrd_clr   (frwrd_clr),
    .frwrd_inc   (frwrd_inc),
    .frwrd_dec   (frwrd_dec)
  );

  frwrd_ramp #(.fast_sim(fast_sim)) u_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .heading_rdy (heading_rdy),
    .frwrd_clr   (frwrd_clr),
    .frwrd_inc   (frwrd_inc),
    .frwrd_dec   (frwrd_dec),
    .frwrd       (frwrd),
    .frwrd_zero  (frwrd_zero)
  );

  square_counter u_sq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_load  (cmd_load),
    .squares   (cmd_f.squares),
    .cntr_ir   (ir.cntr),
    .move_done (move_done)
  );

  heading_err #(.fast_sim(fast_sim)) u_hdg (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_load (cmd_load),
    .hdg_code (cmd_f.hdg_code),
    .heading  (heading),
    .ir       (ir),
    .error    (error),
    .aligned  (aligned)
  );

endmodule

/* tb_clk_gen.sv */
//////////////////////////////
// Testbench clock and reset generator.
//////////////////////////////
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int period     = 8,             // Clock period in ns.
  parameter int rst_cycles = 3              // Cycles with rst_n low.
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #1 rst_n = 1'b1;                        // Release away from the edge.
  end

endmodule

/* tb_monitor.sv */
//////////////////////////////
// Testbench monitor.
// Watches the DUT outputs, compares them per test,
// prints one line per test and keeps the counts.
//////////////////////////////
`timescale 1ns/1ns

module tb_monitor import knight_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     cal_done,
  input logic     cntr_ir,                  // Centre IR as driven.
  input logic     clr_cmd_rdy,
  input logic     send_resp,
  input logic     strt_cal,
  input logic     moving,
  input logic     tour_go,
  input logic     fanfare_go,
  input heading_t error,
  input frwrd_t   frwrd
);

  localparam frwrd_t STEP_UP = 10'h020;     // Fast ramp up step.
  localparam frwrd_t STEP_DN = 10'h040;     // Fast ramp down step.
  localparam frwrd_t TOP_SPD = 10'h300;     // Saturated speed.

  string       name;                        // Current test.
  int          kind;                        // 0 cal, 1 tour, 2 move, 3 fanfare.
  logic [11:0] exp_err;
  int          nsq;
  bit          active, accepted, err_due, fall_seen, moved;
  bit          cal_prev, cntr_prev;
  int          n_resp, n_tour, n_fan, n_clr, edges, test_errs;
  frwrd_t      prev_frwrd, peak;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  task automatic note(input string msg);
    test_errs++;
    $display("%s: %s", name, msg);
  endtask

  task automatic mismatch(input string what, input logic [11:0] exp, input logic [11:0] act);
    test_errs++;
    $display("mismatch %s %s expected 0x%h actual 0x%h", name, what, exp, act);
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("pass %s", name);
    end else begin
      fail_cnt++;
      $display("fail %s with %0d errors", name, test_errs);
    end
    active = 1'b0;
  endtask

  task automatic start_test(input string nm, input int k, input logic [11:0] e, input int n);
    name      = nm;
    kind      = k;
    exp_err   = e;
    nsq       = n;
    accepted  = 1'b0;
    err_due   = 1'b0;
    fall_seen = 1'b0;
    moved     = 1'b0;
    n_resp    = 0;
    n_tour    = 0;
    n_fan     = 0;
    n_clr     = 0;
    edges     = 0;
    test_errs = 0;
    peak      = '0;
    prev_frwrd = frwrd;
    active    = 1'b1;
  endtask

  // Sampled right after reset release, with cmd_rdy low.
  task automatic check_reset();
    name      = "reset";
    test_errs = 0;
    if (clr_cmd_rdy || send_resp || strt_cal || moving || tour_go || fanfare_go)
      note("a control output is high after reset");
    if (frwrd != '0) mismatch("frwrd", 12'h000, {2'b00, frwrd});
    close_test();
  endtask

  task automatic end_test();
    int exp_fan;
    exp_fan = (kind == 3) ? 1 : 0;
    if (n_clr != 1) mismatch("clr_cmd_rdy count", 12'h001, 12'(n_clr));
    case (kind)
      0: begin
        if (n_resp != 1) mismatch("send_resp count", 12'h001, 12'(n_resp));
        if (n_tour != 0) note("tour_go seen during calibration");
      end
      1: begin
        if (n_tour != 1) mismatch("tour_go count", 12'h001, 12'(n_tour));
        if (n_resp != 0) mismatch("send_resp count", 12'h000, 12'(n_resp));
        if (moved) note("robot moved on a tour command");
      end
      default: begin
        if (peak != TOP_SPD) mismatch("frwrd peak", {2'b00, TOP_SPD}, {2'b00, peak});
        if (!fall_seen) note("speed never ramped down");
        if (frwrd != '0) mismatch("final frwrd", 12'h000, {2'b00, frwrd});
        if (n_resp != 1) mismatch("send_resp count", 12'h001, 12'(n_resp));
        if (n_fan != exp_fan) mismatch("fanfare_go count", 12'(exp_fan), 12'(n_fan));
      end
    endcase
    close_test();
  endtask

  task automatic summary();
    $display("tests %0d passed %0d failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
  endtask

  //////////////////////////////
  // Per cycle observation
  always @(posedge clk) begin
    if (active && rst_n) begin
      if (err_due) begin                    // Cycle after the move was loaded.
        err_due = 1'b0;
        if (error !== exp_err) mismatch("error", exp_err, error);
      end
      if (clr_cmd_rdy) n_clr++;             // One cycle per command.
      if (clr_cmd_rdy && !accepted) begin
        accepted = 1'b1;
        edges    = 0;                       // DUT clears its count here too.
        if (kind == 0 && !strt_cal) note("strt_cal low in the acceptance cycle");
        if (kind == 1 && !tour_go) note("tour_go low in the acceptance cycle");
        if (kind >= 2) err_due = 1'b1;
      end
      if (send_resp) begin
        n_resp++;
        if (kind == 0 && !(cal_done && !cal_prev)) note("send_resp not in first cal_done cycle");
      end
      if (tour_go) n_tour++;
      if (fanfare_go) begin
        n_fan++;
        if (fall_seen) note("fanfare_go after the ramp down began");
      end
      if (moving) moved = 1'b1;
      if (kind >= 2 && moved && !moving && frwrd != '0) note("moving low with speed nonzero");
      if (cntr_ir && !cntr_prev) edges++;
      if (frwrd > TOP_SPD) mismatch("frwrd above max", {2'b00, TOP_SPD}, {2'b00, frwrd});
      if (frwrd > prev_frwrd) begin
        if (fall_seen || (frwrd - prev_frwrd) != STEP_UP)
          mismatch("frwrd step up", {2'b00, prev_frwrd + STEP_UP}, {2'b00, frwrd});
      end else if (frwrd < prev_frwrd) begin
        if ((prev_frwrd - frwrd) != STEP_DN)
          mismatch("frwrd step down", {2'b00, prev_frwrd - STEP_DN}, {2'b00, frwrd});
        if (!fall_seen && edges < 2 * nsq) note("speed fell before all squares were crossed");
        fall_seen = 1'b1;
      end
      if (frwrd > peak) peak = frwrd;
      prev_frwrd = frwrd;
    end
    cal_prev  = cal_done;
    cntr_prev = cntr_ir;
  end

endmodule

/* cmd_proc_chk.sv */
//////////////////////////////
// Protocol assertions, bound to the command processor.
//////////////////////////////
`timescale 1ns/1ns

module cmd_proc_chk import knight_pkg::*; #(
  parameter bit fast_sim = 1'b1
) (
  input logic   clk,
  input logic   rst_n,
  input logic   send_resp,
  input logic   tour_go,
  input logic   fanfare_go,
  input logic   strt_cal,
  input logic   clr_cmd_rdy,
  input frwrd_t frwrd
);

  // Strobes last one cycle.
  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n) send_resp |=> !send_resp)
    else $error("send_resp high for two cycles");
  a_tour_pulse: assert property (@(posedge clk) disable iff (!rst_n) tour_go |=> !tour_go)
    else $error("tour_go high for two cycles");
  a_fan_pulse: assert property (@(posedge clk) disable iff (!rst_n) fanfare_go |=> !fanfare_go)
    else $error("fanfare_go high for two cycles");

  a_max_spd: assert property (@(posedge clk) disable iff (!rst_n) fast_sim |-> frwrd <= 10'h300)
    else $error("frwrd above max speed");   // Saturation point of the ramp.

  a_cal_clr: assert property (@(posedge clk) disable iff (!rst_n) strt_cal |-> clr_cmd_rdy)
    else $error("strt_cal without clr_cmd_rdy");

endmodule

bind cmd_proc cmd_proc_chk #(.fast_sim(fast_sim)) u_chk (.*);

/* tb_cmd_proc.sv */
//////////////////////////////
// Testbench top for the command processor.
// Reads the test data file, drives commands, IR and heading_rdy.
//////////////////////////////
`timescale 1ns/1ns

module tb_cmd_proc import knight_pkg::*; ();

  logic     clk, rst_n;
  cmd_t     cmd;
  logic     cmd_rdy, cal_done, heading_rdy;
  heading_t heading;
  ir_t      ir;
  logic     clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go;
  heading_t error;
  frwrd_t   frwrd;

  string       names[$];                    // Test data columns.
  logic [15:0] cmds[$];
  logic [11:0] hdgs[$];
  logic [2:0]  irs[$];
  int          cal_dly[$];
  logic [11:0] exp_errs[$];
  bit          hb_en = 1'b0;                // heading_rdy generator on.
  int          hb_cnt = 0;

  tb_clk_gen #(.period(8), .rst_cycles(3)) u_clk (.clk(clk), .rst_n(rst_n));

  cmd_proc #(.fast_sim(1'b1)) UUT (.*);

  tb_monitor mon (
    .clk(clk), .rst_n(rst_n), .cal_done(cal_done), .cntr_ir(ir.cntr),
    .clr_cmd_rdy(clr_cmd_rdy), .send_resp(send_resp), .strt_cal(strt_cal),
    .moving(moving), .tour_go(tour_go), .fanfare_go(fanfare_go),
    .error(error), .frwrd(frwrd)
  );

  // One heading_rdy pulse every 4 cycles.
  always @(posedge clk) begin
    #1;
    heading_rdy = hb_en && (hb_cnt == 0);
    hb_cnt = (hb_cnt + 1) % 4;
  end

  // Zero code is north, else code then four ones.
  function automatic heading_t desired_heading(input logic [7:0] code);
    return (code == 8'h00) ? heading_t'(12'h000) : heading_t'({code, 4'hF});
  endfunction

  task automatic run_test(input int i);
    cmd_fields_t f;
    int          kind;
    int          gap;
    f = cmds[i];
    case (f.op)
      4'h2:    kind = 0;
      4'h6:    kind = 1;
      4'h5:    kind = 3;
      default: kind = 2;                    // Unlisted codes move.
    endcase
    mon.start_test(names[i], kind, exp_errs[i], int'(f.squares));
    @(posedge clk);
    #1 cmd = cmds[i];
    cmd_rdy = 1'b1;
    do @(posedge clk); while (!clr_cmd_rdy);
    #1 cmd_rdy = 1'b0;
    if (kind == 0) begin
      repeat (cal_dly[i]) @(posedge clk);
      #1 cal_done = 1'b1;
      do @(posedge clk); while (!send_resp);
      repeat (2) @(posedge clk);            // Held on to catch a second response.
      #1 cal_done = 1'b0;
      repeat (2) @(posedge clk);
    end else if (kind == 1) begin
      repeat (8) @(posedge clk);
    end else begin
      heading = hdgs[i];                    // Value checked against the file.
      ir      = irs[i];
      hb_en   = 1'b1;
      @(posedge clk);
      #1 heading = desired_heading(f.hdg_code);
      ir = '0;
      do @(posedge clk); while (frwrd != 10'h300);
      repeat (2 * int'(f.squares)) begin
        #1 ir.cntr = 1'b1;
        repeat (2) @(posedge clk);
        #1 ir.cntr = 1'b0;
        gap = 2 + int'($urandom_range(3, 0));
        repeat (gap) @(posedge clk);
      end
      do @(posedge clk); while (!send_resp);
      #1 hb_en = 1'b0;
      repeat (6) @(posedge clk);
    end
    mon.end_test();
  endtask

  initial begin
    int          fd;
    int          seed;
    int          n;
    int          wd_cycles;
    string       line, nm;
    logic [15:0] c;
    logic [11:0] h, e;
    logic [2:0]  irv;
    int          dly;
    cmd      = '0;
    cmd_rdy  = 1'b0;
    cal_done = 1'b0;
    heading  = '0;
    heading_rdy = 1'b0;
    ir       = '0;
    seed     = $urandom(32'h3e00_3984);
    fd = $fopen("cmd_proc_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      $display("TEST FAILED");
      $finish;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 3 || line[0] == "#") continue;
        n = $sscanf(line, "%s %h %h %h %d %h", nm, c, h, irv, dly, e);
        if (n == 6) begin
          names.push_back(nm);
          cmds.push_back(c);
          hdgs.push_back(h);
          irs.push_back(irv);
          cal_dly.push_back(dly);
          exp_errs.push_back(e);
        end
      end
      $fclose(fd);
      wd_cycles = (names.size() + 1) * 2000;
      fork
        begin
          repeat (wd_cycles) @(posedge clk);
          $display("watchdog expired after %0d cycles, a test hung", wd_cycles);
          $display("TEST FAILED");
          $finish;
        end
      join_none
      @(posedge rst_n);
      @(posedge clk);
      mon.check_reset();
      foreach (names[i]) run_test(i);
      mon.summary();
      if (mon.fail_cnt == 0 && names.size() > 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

/* cmd_proc_testdata.txt */
# name cmd(hex) heading(hex) ir{lft,cntr,rght}(hex) cal_done_delay(dec) expected_error(hex)
# Opcode 2 is CAL, 4 MOV, 5 FANFARE, 6 TOUR, others move.
cal_short 2000 000 0 3 000
cal_long 2000 000 0 10 000
tour 6000 000 0 0 000
mov_north_1 4001 000 0 0 000
mov_east_2 4BF2 000 0 0 401
mov_lft_nudge 43F1 400 4 0 200
mov_rght_nudge 47F3 7F0 1 0 DF1
fanfare_2 5002 010 0 0 010
fanfare_both_ir 5BF1 BFF 5 0 1FF
unknown_op 9001 000 0 0 000

/* flist.f */
knight_pkg.sv
frwrd_ramp.sv
square_counter.sv
heading_err.sv
cmd_fsm.sv
cmd_proc.sv
tb_clk_gen.sv
tb_monitor.sv
cmd_proc_chk.sv
tb_cmd_proc.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_cmd_proc
FLIST     = flist.f

.PHONY: help test clean

help:
	@echo "test   build and run the testbench with Verilator"
	@echo "clean  remove build output"
	@echo "help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
